/* logic/arbPkg.sv */
package arbPkg;

  // Number of request lines
  localparam int LineCnt = 8;

  // Bits needed to number a line
  localparam int IdxW = $clog2(LineCnt);

  // One bit per line
  // Carries raw requests, filtered requests, the pointer and grants
  typedef logic [LineCnt-1:0] lineVecT;

  // Unsigned line number
  typedef logic [IdxW-1:0] lineIdxT;

  // No line selected
  localparam lineVecT LineNone = '0;

  // Only line 0 selected, the pointer start position
  localparam lineVecT LineFirst = lineVecT'(1);

  // Index value for line 0, also the idle index
  localparam lineIdxT IdxNone = '0;

endpackage

/* logic/glitchPkg.sv */
package glitchPkg;

  // Identical samples needed before a filtered level may change
  localparam int FilterLen = 4;

  // Sample history of one line, newest sample in bit 0
  typedef logic [FilterLen-1:0] filterHistT;

  // History value that means a steady high input
  localparam filterHistT HistHigh = '1;

  // History value that means a steady low input
  localparam filterHistT HistLow = '0;

endpackage

/* logic/glitchFilter.sv */
`timescale 1ns/1ps

module glitchFilter
(
  input  logic            AClkB,
  input  logic            AResetBN,
  input  arbPkg::lineVecT reqRaw,
  output arbPkg::lineVecT reqFilt
);

  import arbPkg::*;
  import glitchPkg::*;

  // One independent filter per request line
  for (genvar lineI = 0; lineI < LineCnt; lineI++)
  begin : gLine

    filterHistT hist;
    logic       histHigh;
    logic       histLow;
    logic       lvl;
    logic       lvlNext;

    // Only a full run of equal samples moves the level
    assign histHigh = (hist == HistHigh);
    assign histLow  = (hist == HistLow);

    always_comb
    begin
      if (histHigh)
      begin
        lvlNext = 1'b1;
      end
      else if (histLow)
      begin
        lvlNext = 1'b0;
      end
      else
      begin
        lvlNext = lvl;
      end
    end

    always_ff @(posedge AClkB or negedge AResetBN)
    begin
      if (AResetBN == 1'b0)
      begin
        hist <= HistLow;
        lvl  <= 1'b0;
      end
      else
      begin
        hist <= {hist[FilterLen-2:0], reqRaw[lineI]};
        lvl  <= lvlNext;
      end
    end

    assign reqFilt[lineI] = lvl;

  end

endmodule

/* logic/rrPrioritize.sv */
`timescale 1ns/1ps

module rrPrioritize
(
  input  logic            AClkB,
  input  logic            AResetBN,
  input  arbPkg::lineVecT reqFilt,
  output arbPkg::lineVecT grantNext
);

  import arbPkg::*;

  lineVecT ptr;
  lineVecT ptrNext;
  lineVecT ptrStep;
  lineVecT grantPrev;
  lineVecT reqRot;
  lineVecT grantRot;
  lineVecT grantComb;
  logic    reqAny;
  logic    grantHeld;

  // Rotate right so that the pointer line lands on bit 0
  // The pointer is one-hot, so each set bit picks one rotation amount
  function automatic lineVecT rotRight(lineVecT vec, lineVecT sel);
    lineVecT res;
    res = LineNone;
    for (int k = 0; k < LineCnt; k++)
    begin
      for (int j = 0; j < LineCnt; j++)
      begin
        res[j] = res[j] | (sel[k] & vec[(j + k) % LineCnt]);
      end
    end
    return res;
  endfunction

  // Inverse of rotRight for the same pointer
  function automatic lineVecT rotLeft(lineVecT vec, lineVecT sel);
    lineVecT res;
    res = LineNone;
    for (int k = 0; k < LineCnt; k++)
    begin
      for (int j = 0; j < LineCnt; j++)
      begin
        res[j] = res[j] | (sel[k] & vec[(j - k + LineCnt) % LineCnt]);
      end
    end
    return res;
  endfunction

  // Keep only the lowest set bit
  // seen[j] tells whether any bit at or below j is set
  function automatic lineVecT lowestSet(lineVecT vec);
    lineVecT seen;
    lineVecT res;
    seen    = LineNone;
    res     = LineNone;
    seen[0] = vec[0];
    res[0]  = vec[0];
    for (int j = 1; j < LineCnt; j++)
    begin
      res[j]  = vec[j] & ~seen[j-1];
      seen[j] = vec[j] | seen[j-1];
    end
    return res;
  endfunction

  // Scan upward from the pointer line, wrapping past the top line
  assign reqRot    = rotRight(reqFilt, ptr);
  assign grantRot  = lowestSet(reqRot);
  assign grantComb = rotLeft(grantRot, ptr);

  assign reqAny    = |reqFilt;
  // Granted line still asking, so the pointer stays put
  assign grantHeld = |(reqFilt & grantPrev);

  // One position upward, top line wraps to line 0
  assign ptrStep = {ptr[LineCnt-2:0], ptr[LineCnt-1]};

  always_comb
  begin
    if (ptr == LineNone)
    begin
      ptrNext = LineFirst;
    end
    else if (reqAny && !grantHeld)
    begin
      ptrNext = ptrStep;
    end
    else
    begin
      ptrNext = ptr;
    end
  end

  always_ff @(posedge AClkB or negedge AResetBN)
  begin
    if (AResetBN == 1'b0)
    begin
      ptr       <= LineNone;
      grantPrev <= LineNone;
    end
    else
    begin
      ptr       <= ptrNext;
      grantPrev <= grantComb;
    end
  end

  assign grantNext = grantPrev;

endmodule

/* logic/grantEncode.sv */
`timescale 1ns/1ps

module grantEncode
(
  input  logic             AClkB,
  input  logic             AResetBN,
  input  arbPkg::lineVecT  grantNext,
  output arbPkg::lineVecT  grant,
  output arbPkg::lineIdxT  grantIdx,
  output logic             grantValid
);

  import arbPkg::*;

  lineIdxT idxComb;
  logic    validComb;

  // Index of a one-hot vector
  // Each set bit contributes its own position, so line 0 and idle both give 0
  function automatic lineIdxT idxOf(lineVecT vec);
    lineIdxT idx;
    idx = IdxNone;
    for (int j = 0; j < LineCnt; j++)
    begin
      if (vec[j])
      begin
        idx = idx | lineIdxT'(j);
      end
    end
    return idx;
  endfunction

  assign idxComb   = idxOf(grantNext);
  assign validComb = |grantNext;

  // All three outputs move on the same edge
  always_ff @(posedge AClkB or negedge AResetBN)
  begin
    if (AResetBN == 1'b0)
    begin
      grant      <= LineNone;
      grantIdx   <= IdxNone;
      grantValid <= 1'b0;
    end
    else
    begin
      grant      <= grantNext;
      grantIdx   <= idxComb;
      grantValid <= validComb;
    end
  end

endmodule

/* logic/arbTop.sv */
`timescale 1ns/1ps

module arbTop
(
  input  logic            AClkB,
  input  logic            AResetBN,
  input  arbPkg::lineVecT reqRaw,
  output arbPkg::lineVecT grant,
  output arbPkg::lineIdxT grantIdx,
  output logic            grantValid
);

  import arbPkg::*;

  // Steady request levels
  lineVecT reqFilt;

  // One-hot grant from the round-robin stage
  lineVecT grantNext;

  // Stage 1
  glitchFilter uFilter
  (
    .AClkB    (AClkB),
    .AResetBN (AResetBN),
    .reqRaw   (reqRaw),
    .reqFilt  (reqFilt)
  );

  // Stage 2
  rrPrioritize uPrio
  (
    .AClkB     (AClkB),
    .AResetBN  (AResetBN),
    .reqFilt   (reqFilt),
    .grantNext (grantNext)
  );

  // Stage 3
  grantEncode uEncode
  (
    .AClkB      (AClkB),
    .AResetBN   (AResetBN),
    .grantNext  (grantNext),
    .grant      (grant),
    .grantIdx   (grantIdx),
    .grantValid (grantValid)
  );

endmodule

/* test/arbTop_sva.sv */
`timescale 1ns/1ps

module arbTopSva
(
  input logic            AClkB,
  input logic            AResetBN,
  input arbPkg::lineVecT reqRaw,
  input arbPkg::lineVecT grant,
  input arbPkg::lineIdxT grantIdx,
  input logic            grantValid
);

  import arbPkg::*;
  import glitchPkg::*;

  // Number of failed assertions, read by the testbench
  int errCnt = 0;

  // Outputs cleared while reset is held
  resetClear: assert property (@(posedge AClkB)
    !AResetBN |-> (grant == LineNone && grantIdx == IdxNone && !grantValid))
  else
  begin
    $error("grant outputs not cleared while reset is asserted");
    errCnt++;
  end

  // Values loaded by the first edge after release are still idle
  releaseClear: assert property (@(posedge AClkB)
    $rose(AResetBN) |=> (grant == LineNone && grantIdx == IdxNone && !grantValid))
  else
  begin
    $error("grant outputs not cleared on the first edge after reset");
    errCnt++;
  end

  validMatchesGrant: assert property (@(posedge AClkB)
    grantValid == (grant != LineNone))
  else
  begin
    $error("grantValid does not match the OR of grant");
    errCnt++;
  end

  grantOneHot: assert property (@(posedge AClkB)
    $onehot0(grant))
  else
  begin
    $error("more than one grant bit set");
    errCnt++;
  end

  idxMatchesGrant: assert property (@(posedge AClkB)
    grantValid |-> (grant == (LineFirst << grantIdx)))
  else
  begin
    $error("grantIdx does not point at the granted line");
    errCnt++;
  end

  // A new grant needs one line high for a full filter run, 7 to 4 edges back
  riseNeedsRun: assert property (@(posedge AClkB) disable iff (!AResetBN)
    $rose(grantValid) |-> |($past(reqRaw, FilterLen + 3) & $past(reqRaw, FilterLen + 2)
                            & $past(reqRaw, FilterLen + 1) & $past(reqRaw, FilterLen)))
  else
  begin
    $error("grantValid rose without a steady raw request run");
    errCnt++;
  end

endmodule

bind arbTop arbTopSva uSva
(
  .AClkB      (AClkB),
  .AResetBN   (AResetBN),
  .reqRaw     (reqRaw),
  .grant      (grant),
  .grantIdx   (grantIdx),
  .grantValid (grantValid)
);

/* test/arbTopTb.sv */
`timescale 1ns/1ps

module arbTopTb;

  import arbPkg::*;
  import glitchPkg::*;

  // Raw request to grant output, in cycles
  localparam int Lat         = FilterLen + 3;
  localparam int ResetCycles = 5;
  localparam int IdleCycles  = 3;
  localparam int HoldCycles  = 12;
  localparam int NumSingles  = 3;
  localparam int NumPulses   = 40;
  // Longest glitch plus longest gap after it
  localparam int PulseMax    = (FilterLen - 1) + (FilterLen + 2);
  localparam int PairLen     = 3 * Lat + 2 * HoldCycles;
  localparam int SingleLen   = 2 * Lat + HoldCycles;
  localparam int GlitchLen   = NumPulses * PulseMax + Lat;
  localparam int CycleLimit  = ResetCycles + IdleCycles + PairLen + NumSingles * SingleLen
                               + GlitchLen + 50;

  logic        AClkB;
  logic        AResetBN;
  lineVecT     reqRaw;
  lineVecT     grant;
  lineIdxT     grantIdx;
  logic        grantValid;

  logic [31:0] rngState;
  int          cycleCnt = 0;

  arbTop u_dut
  (
    .AClkB      (AClkB),
    .AResetBN   (AResetBN),
    .reqRaw     (reqRaw),
    .grant      (grant),
    .grantIdx   (grantIdx),
    .grantValid (grantValid)
  );

  initial
  begin
    AClkB = 1'b0;
    forever #10 AClkB = ~AClkB;
  end

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  task automatic stopRun();
    $display("Checks failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic reportValue(string sigName, logic [31:0] got, logic [31:0] exp);
    $display("[FAIL] %s: got 0x%0h, expected 0x%0h", sigName, got, exp);
    stopRun();
  endtask

  task automatic reportEvent(string what);
    $display("%s", what);
    stopRun();
  endtask

  // line < 0 means no grant expected
  task automatic expectGrant(int line);
    lineVecT expGrant;
    logic    expValid;
    expGrant = (line < 0) ? LineNone : (LineFirst << line);
    expValid = (line >= 0);
    assert (grant == expGrant) else reportValue("grant", 32'(grant), 32'(expGrant));
    assert (grantValid == expValid)
      else reportValue("grantValid", 32'(grantValid), 32'(expValid));
    if (line >= 0)
    begin
      assert (grantIdx == lineIdxT'(line))
        else reportValue("grantIdx", 32'(grantIdx), 32'(line));
    end
  endtask

  // Old grant for Lat-1 cycles after the drive, new grant on cycle Lat
  task automatic crossPipeline(int lineBefore, int lineAfter);
    repeat (Lat - 1)
    begin
      @(negedge AClkB);
      expectGrant(lineBefore);
    end
    @(negedge AClkB);
    expectGrant(lineAfter);
  endtask

  task automatic holdSteady(int line);
    repeat (HoldCycles)
    begin
      @(negedge AClkB);
      expectGrant(line);
    end
  endtask

  task automatic runSingle(int line);
    reqRaw = LineFirst << line;
    crossPipeline(-1, line);
    holdSteady(line);
    reqRaw = LineNone;
    crossPipeline(line, -1);
  endtask

  // Pulses of 1 to FilterLen-1 cycles with gaps of at least FilterLen cycles
  task automatic sendGlitches();
    lineVecT mask;
    int      pulseLen;
    int      gapLen;
    for (int p = 0; p < NumPulses; p++)
    begin
      rngState = xorshift32(rngState);
      mask     = lineVecT'(rngState);
      if (mask == LineNone)
      begin
        mask = LineFirst;
      end
      pulseLen = 1 + int'(rngState[15:8] % (FilterLen - 1));
      gapLen   = FilterLen + int'(rngState[23:16] % 3);
      reqRaw = mask;
      repeat (pulseLen)
      begin
        @(negedge AClkB);
        expectGrant(-1);
      end
      reqRaw = LineNone;
      repeat (gapLen)
      begin
        @(negedge AClkB);
        expectGrant(-1);
      end
    end
    repeat (Lat)
    begin
      @(negedge AClkB);
      expectGrant(-1);
    end
  endtask

  always @(negedge AClkB)
  begin
    cycleCnt = cycleCnt + 1;
    if (u_dut.uSva.errCnt != 0)
    begin
      reportEvent("an assertion on the DUT ports failed");
    end
    else if (cycleCnt > CycleLimit)
    begin
      reportEvent("timeout, the run did not finish within the cycle limit");
    end
  end

  initial
  begin
    AResetBN = 1'b0;
    reqRaw   = LineNone;
    rngState = 32'ha749_3263;
    repeat (ResetCycles)
    begin
      @(negedge AClkB);
      expectGrant(-1);
    end
    AResetBN = 1'b1;
    repeat (IdleCycles)
    begin
      @(negedge AClkB);
      expectGrant(-1);
    end

    // Pointer still at line 0, so the lower line wins
    reqRaw = (LineFirst << 2) | (LineFirst << 6);
    crossPipeline(-1, 2);
    holdSteady(2);
    reqRaw[2] = 1'b0;
    crossPipeline(2, 6);
    holdSteady(6);
    reqRaw[6] = 1'b0;
    crossPipeline(6, -1);

    runSingle(0);
    runSingle(3);
    runSingle(7);

    sendGlitches();

    if (u_dut.uSva.errCnt == 0)
    begin
      $display("All checks passed");
      $finish;
    end
    else
    begin
      reportEvent("an assertion on the DUT ports failed");
    end
  end

endmodule

/* vlog.f */
logic/arbPkg.sv
logic/glitchPkg.sv
logic/glitchFilter.sv
logic/rrPrioritize.sv
logic/grantEncode.sv
logic/arbTop.sv
test/arbTop_sva.sv
test/arbTopTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert --timing -j 0
TOP       = arbTopTb
FILELIST  = vlog.f
OBJDIR    = obj_dir
SIMARGS   = +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) $(SIMARGS)

clean:
	rm -rf $(OBJDIR)
